// ==== design/icache_geom_pkg.sv ====
//////////////////////////////////////////////////
// Instruction cache geometry
//////////////////////////////////////////////////
package icache_geom_pkg;

  // Sizes
  localparam int addr_width_c  = 16;
  localparam int sets_c        = 16;
  localparam int ways_c        = 2;
  localparam int word_width_c  = 32;
  localparam int block_width_c = 64;

  // Byte offset, word select, index and tag from low bits to high bits
  localparam int word_sel_bit_c = 2;
  localparam int index_lsb_c    = 3;
  localparam int index_width_c  = 4;
  localparam int tag_lsb_c      = index_lsb_c + index_width_c;
  localparam int tag_width_c    = addr_width_c - tag_lsb_c;

  typedef logic [addr_width_c-1:0]  addr_t;
  typedef logic [index_width_c-1:0] index_t;
  typedef logic [tag_width_c-1:0]   tag_t;
  typedef logic [word_width_c-1:0]  word_t;
  typedef logic [block_width_c-1:0] block_t;

  // Way number and per-way flags
  typedef logic                     way_t;
  typedef logic [ways_c-1:0]        way_mask_t;

endpackage

// ==== design/icache_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Instruction cache control encodings
//////////////////////////////////////////////////
package icache_ctrl_pkg;

  // Operation carried by a fetch packet
  typedef enum logic
  {
    e_op_fetch = 1'b0,
    e_op_flush = 1'b1
  } fetch_op_e;

  // Miss handling
  typedef enum logic
  {
    e_ready = 1'b0,
    e_miss  = 1'b1
  } miss_state_e;

endpackage

// ==== design/icache_fetch_stage.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Fetch decode stage
//////////////////////////////////////////////////
module icache_fetch_stage
  (input  logic                        clk_i
   , input  logic                      reset_i

   , input  logic                      fetch_v_i
   , input  icache_ctrl_pkg::fetch_op_e fetch_op_i
   , input  icache_geom_pkg::addr_t    fetch_vaddr_i
   , input  logic                      ready_i

   , output logic                      rd_v_o
   , output icache_geom_pkg::index_t   rd_index_o
   , output logic                      flush_o

   , output logic                      tl_v_o
   , output icache_geom_pkg::addr_t    tl_vaddr_o
   );

  import icache_geom_pkg::*;
  import icache_ctrl_pkg::*;

  logic accept;
  logic is_fetch;
  logic is_flush;

  assign accept   = fetch_v_i & ready_i;
  assign is_fetch = (fetch_op_i == e_op_fetch);
  assign is_flush = (fetch_op_i == e_op_flush);

  // Both arrays are read at the virtual index in the decode cycle
  assign rd_v_o     = accept & is_fetch;
  assign rd_index_o = fetch_vaddr_i[index_lsb_c +: index_width_c];

  // Flush clears valid bits at the end of this cycle
  assign flush_o = accept & is_flush;

  //////////////////////////////////////////////////
  // Tag lookup registers

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_o <= 1'b0;
    end
    else
    begin
      tl_v_o <= rd_v_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_v_o)
    begin
      tl_vaddr_o <= fetch_vaddr_i;
    end
  end

endmodule

// ==== design/icache_tag_array.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Tag and valid storage
//////////////////////////////////////////////////
module icache_tag_array
  #(parameter int sets_p = icache_geom_pkg::sets_c)
  (input  logic                       clk_i
   , input  logic                     reset_i

   , input  logic                     rd_v_i
   , input  icache_geom_pkg::index_t  rd_index_i
   , input  logic                     flush_i

   , input  logic                     wr_v_i
   , input  icache_geom_pkg::index_t  wr_index_i
   , input  icache_geom_pkg::way_t    wr_way_i
   , input  icache_geom_pkg::tag_t    wr_tag_i

   , output icache_geom_pkg::tag_t [icache_geom_pkg::ways_c-1:0] tags_o
   , output icache_geom_pkg::way_mask_t valid_o
   );

  import icache_geom_pkg::*;

  tag_t      tag_mem [ways_c][sets_p];
  way_mask_t valid_r [sets_p];

  // Tag memory with synchronous read, output held between reads
  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
    begin
      tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
    end
    if (rd_v_i)
    begin
      for (int w = 0; w < ways_c; w++)
      begin
        tags_o[w] <= tag_mem[w][rd_index_i];
      end
      valid_o <= valid_r[rd_index_i];
    end
  end

  // Valid bits live in flops so a flush clears every set at once
  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      for (int s = 0; s < sets_p; s++)
      begin
        valid_r[s] <= '0;
      end
    end
    else if (wr_v_i)
    begin
      valid_r[wr_index_i][wr_way_i] <= 1'b1;
    end
  end

endmodule

// ==== design/icache_data_array.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Cache block storage
//////////////////////////////////////////////////
module icache_data_array
  #(parameter int sets_p = icache_geom_pkg::sets_c)
  (input  logic                       clk_i

   , input  logic                     rd_v_i
   , input  icache_geom_pkg::index_t  rd_index_i

   , input  logic                     wr_v_i
   , input  icache_geom_pkg::index_t  wr_index_i
   , input  icache_geom_pkg::way_t    wr_way_i
   , input  icache_geom_pkg::block_t  wr_data_i

   , output icache_geom_pkg::block_t [icache_geom_pkg::ways_c-1:0] blocks_o
   );

  import icache_geom_pkg::*;

  block_t data_mem [ways_c][sets_p];

  // Both ways read together, last read value stays on the output
  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
    begin
      data_mem[wr_way_i][wr_index_i] <= wr_data_i;
    end
    if (rd_v_i)
    begin
      for (int w = 0; w < ways_c; w++)
      begin
        blocks_o[w] <= data_mem[w][rd_index_i];
      end
    end
  end

  // Fills only land while fetch acceptance is blocked
  assert property (@(posedge clk_i) !(rd_v_i && wr_v_i))
    else $error("data array read and write in the same cycle");

endmodule

// ==== design/icache_hit_select.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Tag compare and hit data select
//////////////////////////////////////////////////
module icache_hit_select
  #(parameter int sets_p = icache_geom_pkg::sets_c)
  (input  logic                       clk_i
   , input  logic                     reset_i

   , input  logic                     tl_v_i
   , input  icache_geom_pkg::addr_t   tl_vaddr_i
   , input  icache_geom_pkg::tag_t    ptag_i
   , input  logic                     ptag_v_i

   , input  icache_geom_pkg::tag_t   [icache_geom_pkg::ways_c-1:0] tags_i
   , input  icache_geom_pkg::way_mask_t valid_i
   , input  icache_geom_pkg::block_t [icache_geom_pkg::ways_c-1:0] blocks_i

   , input  logic                     busy_i

   , output icache_geom_pkg::word_t   data_o
   , output logic                     data_v_o
   , output logic                     miss_v_o
   , output icache_geom_pkg::addr_t   miss_addr_o
   , output icache_geom_pkg::way_t    repl_way_o
   );

  import icache_geom_pkg::*;

  way_mask_t           hit_tl;
  logic                tv_we;
  logic                tv_v_r;
  way_mask_t           hit_tv_r;
  way_mask_t           valid_tv_r;
  addr_t               paddr_tv_r;
  block_t [ways_c-1:0] blocks_tv_r;
  logic                hit_tv;
  way_t                hit_way;
  block_t              hit_block;
  index_t              tv_index;
  logic [sets_p-1:0]   lru_r;

  //////////////////////////////////////////////////
  // Tag lookup

  always_comb
  begin
    for (int w = 0; w < ways_c; w++)
    begin
      hit_tl[w] = valid_i[w] && (tags_i[w] == ptag_i);
    end
  end

  // Without a translated tag the fetch is dropped
  assign tv_we = tl_v_i & ptag_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tv_v_r <= 1'b0;
    end
    else
    begin
      tv_v_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tv_we)
    begin
      hit_tv_r    <= hit_tl;
      valid_tv_r  <= valid_i;
      paddr_tv_r  <= {ptag_i, tl_vaddr_i[tag_lsb_c-1:0]};
      blocks_tv_r <= blocks_i;
    end
  end

  //////////////////////////////////////////////////
  // Tag verify

  assign hit_tv    = |hit_tv_r;
  assign hit_way   = way_t'(hit_tv_r[1]);
  assign hit_block = blocks_tv_r[hit_way];
  assign tv_index  = paddr_tv_r[index_lsb_c +: index_width_c];
  assign data_o    = hit_block[paddr_tv_r[word_sel_bit_c]*word_width_c +: word_width_c];

  assign data_v_o = tv_v_r & hit_tv;
  // A miss behind an outstanding one is squashed
  assign miss_v_o = tv_v_r & ~hit_tv & ~busy_i;

  assign miss_addr_o = {paddr_tv_r[addr_width_c-1:index_lsb_c], {index_lsb_c{1'b0}}};

  // Invalid way first, lowest number wins, else the LRU way
  assign repl_way_o = !valid_tv_r[0] ? 1'b0
                    : !valid_tv_r[1] ? 1'b1
                    : way_t'(lru_r[tv_index]);

  // LRU bit names the way to replace next
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lru_r <= '0;
    end
    else if (data_v_o)
    begin
      lru_r[tv_index] <= ~hit_way;
    end
  end

  // Fills never install a tag that is already present in the set
  assert property (@(posedge clk_i) disable iff (reset_i) tv_v_r |-> $onehot0(hit_tv_r))
    else $error("tag hit in more than one way");

endmodule

// ==== design/icache_miss_ctrl.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Miss request and fill control
//////////////////////////////////////////////////
module icache_miss_ctrl
  (input  logic                       clk_i
   , input  logic                     reset_i

   , input  logic                     miss_v_i
   , input  icache_geom_pkg::addr_t   miss_addr_i
   , input  icache_geom_pkg::way_t    repl_way_i

   , output logic                     cache_req_v_o
   , output icache_geom_pkg::addr_t   cache_req_addr_o
   , output icache_geom_pkg::way_t    cache_req_way_o
   , input  logic                     cache_req_ready_i
   , input  logic                     fill_v_i
   , input  icache_geom_pkg::block_t  fill_data_i

   , output logic                     wr_v_o
   , output icache_geom_pkg::index_t  wr_index_o
   , output icache_geom_pkg::way_t    wr_way_o
   , output icache_geom_pkg::tag_t    wr_tag_o
   , output icache_geom_pkg::block_t  wr_data_o

   , output logic                     busy_o
   , output logic                     ready_o
   );

  import icache_geom_pkg::*;
  import icache_ctrl_pkg::*;

  miss_state_e state_r;
  miss_state_e state_n;
  logic        is_ready;
  logic        is_miss;
  logic        req_sent_r;
  addr_t       miss_addr_r;
  way_t        miss_way_r;

  assign is_ready = (state_r == e_ready);
  assign is_miss  = (state_r == e_miss);

  //////////////////////////////////////////////////
  // Miss FSM

  always_comb
  begin
    case (state_r)
      e_ready: state_n = miss_v_i ? e_miss : e_ready;
      e_miss:  state_n = fill_v_i ? e_ready : e_miss;
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_ready;
      req_sent_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (wr_v_o)
      begin
        req_sent_r <= 1'b0;
      end
      else if (cache_req_v_o && cache_req_ready_i)
      begin
        req_sent_r <= 1'b1;
      end
    end
  end

  // Miss address and victim way stay put until the fill
  always_ff @(posedge clk_i)
  begin
    if (is_ready && miss_v_i)
    begin
      miss_addr_r <= miss_addr_i;
      miss_way_r  <= repl_way_i;
    end
  end

  // Request goes out in the miss cycle and holds until taken
  assign cache_req_v_o    = (is_ready & miss_v_i) | (is_miss & ~req_sent_r);
  assign cache_req_addr_o = is_ready ? miss_addr_i : miss_addr_r;
  assign cache_req_way_o  = is_ready ? repl_way_i : miss_way_r;

  // Single fill beat writes tag, valid and block
  assign wr_v_o     = is_miss & fill_v_i;
  assign wr_index_o = miss_addr_r[index_lsb_c +: index_width_c];
  assign wr_way_o   = miss_way_r;
  assign wr_tag_o   = miss_addr_r[tag_lsb_c +: tag_width_c];
  assign wr_data_o  = fill_data_i;

  assign busy_o  = is_miss;
  assign ready_o = is_ready & ~miss_v_i;

  // Memory only answers a request it has taken
  assert property (@(posedge clk_i) disable iff (reset_i) fill_v_i |-> is_miss && req_sent_r)
    else $error("fill without an outstanding request");

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// L1 instruction cache
//////////////////////////////////////////////////
module icache_top
  #(parameter int sets_p = icache_geom_pkg::sets_c)
  (input  logic                        clk_i
   , input  logic                      reset_i

   // Decode
   , input  logic                      fetch_v_i
   , input  icache_ctrl_pkg::fetch_op_e fetch_op_i
   , input  icache_geom_pkg::addr_t    fetch_vaddr_i
   , output logic                      ready_o

   // Tag lookup
   , input  icache_geom_pkg::tag_t     ptag_i
   , input  logic                      ptag_v_i

   // Tag verify
   , output icache_geom_pkg::word_t    data_o
   , output logic                      data_v_o
   , output logic                      miss_v_o

   // Memory side
   , output logic                      cache_req_v_o
   , output icache_geom_pkg::addr_t    cache_req_addr_o
   , output icache_geom_pkg::way_t     cache_req_way_o
   , input  logic                      cache_req_ready_i
   , input  logic                      fill_v_i
   , input  icache_geom_pkg::block_t   fill_data_i
   );

  import icache_geom_pkg::*;

  logic                rd_v;
  index_t              rd_index;
  logic                flush;
  logic                tl_v;
  addr_t               tl_vaddr;
  tag_t   [ways_c-1:0] tags;
  way_mask_t           valid;
  block_t [ways_c-1:0] blocks;
  logic                busy;
  addr_t               miss_addr;
  way_t                repl_way;
  logic                wr_v;
  index_t              wr_index;
  way_t                wr_way;
  tag_t                wr_tag;
  block_t              wr_data;

  icache_fetch_stage fetch_stage
    (.clk_i(clk_i), .reset_i(reset_i)
     , .fetch_v_i(fetch_v_i), .fetch_op_i(fetch_op_i), .fetch_vaddr_i(fetch_vaddr_i)
     , .ready_i(ready_o)
     , .rd_v_o(rd_v), .rd_index_o(rd_index), .flush_o(flush)
     , .tl_v_o(tl_v), .tl_vaddr_o(tl_vaddr)
     );

  icache_tag_array #(.sets_p(sets_p)) tag_array
    (.clk_i(clk_i), .reset_i(reset_i)
     , .rd_v_i(rd_v), .rd_index_i(rd_index), .flush_i(flush)
     , .wr_v_i(wr_v), .wr_index_i(wr_index), .wr_way_i(wr_way), .wr_tag_i(wr_tag)
     , .tags_o(tags), .valid_o(valid)
     );

  icache_data_array #(.sets_p(sets_p)) data_array
    (.clk_i(clk_i)
     , .rd_v_i(rd_v), .rd_index_i(rd_index)
     , .wr_v_i(wr_v), .wr_index_i(wr_index), .wr_way_i(wr_way), .wr_data_i(wr_data)
     , .blocks_o(blocks)
     );

  icache_hit_select #(.sets_p(sets_p)) hit_select
    (.clk_i(clk_i), .reset_i(reset_i)
     , .tl_v_i(tl_v), .tl_vaddr_i(tl_vaddr), .ptag_i(ptag_i), .ptag_v_i(ptag_v_i)
     , .tags_i(tags), .valid_i(valid), .blocks_i(blocks), .busy_i(busy)
     , .data_o(data_o), .data_v_o(data_v_o), .miss_v_o(miss_v_o)
     , .miss_addr_o(miss_addr), .repl_way_o(repl_way)
     );

  icache_miss_ctrl miss_ctrl
    (.clk_i(clk_i), .reset_i(reset_i)
     , .miss_v_i(miss_v_o), .miss_addr_i(miss_addr), .repl_way_i(repl_way)
     , .cache_req_v_o(cache_req_v_o), .cache_req_addr_o(cache_req_addr_o)
     , .cache_req_way_o(cache_req_way_o), .cache_req_ready_i(cache_req_ready_i)
     , .fill_v_i(fill_v_i), .fill_data_i(fill_data_i)
     , .wr_v_o(wr_v), .wr_index_o(wr_index), .wr_way_o(wr_way)
     , .wr_tag_o(wr_tag), .wr_data_o(wr_data)
     , .busy_o(busy), .ready_o(ready_o)
     );

endmodule

// ==== bench/icache_tb_checks.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Cache response checker
//////////////////////////////////////////////////
module icache_tb_checks
  (input  logic                        clk_i
   , input  logic                      reset_i
   , input  logic                      fetch_v_i
   , input  icache_ctrl_pkg::fetch_op_e fetch_op_i
   , input  icache_geom_pkg::addr_t    fetch_vaddr_i
   , input  logic                      ptag_v_i
   , input  logic                      ready_i
   , input  icache_geom_pkg::word_t    data_i
   , input  logic                      data_v_i
   , input  logic                      miss_v_i
   , input  logic                      cache_req_v_i
   , input  icache_geom_pkg::addr_t    cache_req_addr_i
   , input  icache_geom_pkg::way_t     cache_req_way_i
   , input  logic                      cache_req_ready_i
   , input  logic                      fill_v_i
   , input  logic                      exp_hit_i
   , input  icache_geom_pkg::way_t     exp_way_i
   , output int                        errors_o
   );

  import icache_geom_pkg::*;
  import icache_ctrl_pkg::*;

  int    error_count = 0;
  logic  reset_d_r;
  logic  acc_d1_r;
  logic  acc_d2_r;
  logic  ptag_d1_r;
  logic  hold_r;
  logic  fill_d_r;
  logic  outstanding_r;
  addr_t addr_d1_r;
  addr_t addr_d2_r;
  addr_t req_addr_r;
  way_t  req_way_r;

  assign errors_o = error_count;

  // Memory content of one word, from its address
  function automatic word_t expected_word(input addr_t a);
    return {16'h0000, {2'b00, a[15:2]} ^ 16'hA5C3};
  endfunction

  task automatic count_error();
    error_count++;
  endtask

  //////////////////////////////////////////////////
  // History of the inputs the results depend on

  always_ff @(posedge clk_i)
  begin
    reset_d_r  <= reset_i;
    addr_d1_r  <= fetch_vaddr_i;
    addr_d2_r  <= addr_d1_r;
    req_addr_r <= cache_req_addr_i;
    req_way_r  <= cache_req_way_i;
    if (reset_i)
    begin
      acc_d1_r      <= 1'b0;
      acc_d2_r      <= 1'b0;
      ptag_d1_r     <= 1'b0;
      hold_r        <= 1'b0;
      fill_d_r      <= 1'b0;
      outstanding_r <= 1'b0;
    end
    else
    begin
      acc_d1_r  <= fetch_v_i && ready_i && (fetch_op_i == e_op_fetch);
      acc_d2_r  <= acc_d1_r;
      ptag_d1_r <= ptag_v_i;
      hold_r    <= cache_req_v_i && !cache_req_ready_i;
      fill_d_r  <= fill_v_i;
      if (miss_v_i)
      begin
        outstanding_r <= 1'b1;
      end
      else if (fill_v_i)
      begin
        outstanding_r <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Result timing and content

  assert property (@(posedge clk_i) disable iff (reset_i)
                   acc_d2_r && ptag_d1_r |-> data_v_i || miss_v_i)
  else
  begin
    $display("no hit or miss two cycles after an accepted fetch");
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   !(acc_d2_r && ptag_d1_r) |-> !data_v_i && !miss_v_i)
  else
  begin
    $display("result without a translated fetch two cycles earlier");
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   data_v_i |-> data_i == expected_word(addr_d2_r))
  else
  begin
    $display("Error data_o got %h expected %h", data_i, expected_word(addr_d2_r));
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i) data_v_i |-> exp_hit_i)
  else
  begin
    $display("Error data_v_o got %h expected %h", data_v_i, 1'b0);
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i) miss_v_i |-> !exp_hit_i)
  else
  begin
    $display("Error miss_v_o got %h expected %h", miss_v_i, 1'b0);
    count_error();
  end

  //////////////////////////////////////////////////
  // Miss request and blocking

  assert property (@(posedge clk_i) disable iff (reset_i)
                   miss_v_i |-> cache_req_v_i && cache_req_addr_i == {addr_d2_r[15:3], 3'b000})
  else
  begin
    $display("Error cache_req_addr_o got %h expected %h", cache_req_addr_i,
             {addr_d2_r[15:3], 3'b000});
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   miss_v_i |-> cache_req_way_i == exp_way_i)
  else
  begin
    $display("Error cache_req_way_o got %h expected %h", cache_req_way_i, exp_way_i);
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   miss_v_i || outstanding_r |-> !ready_i)
  else
  begin
    $display("Error ready_o got %h expected %h", ready_i, 1'b0);
    count_error();
  end

  assert property (@(posedge clk_i) disable iff (reset_i) fill_d_r |-> ready_i)
  else
  begin
    $display("Error ready_o got %h expected %h", ready_i, 1'b1);
    count_error();
  end

  // Request must hold still while memory stalls
  assert property (@(posedge clk_i) disable iff (reset_i)
                   hold_r |-> cache_req_v_i && cache_req_addr_i == req_addr_r
                              && cache_req_way_i == req_way_r)
  else
  begin
    $display("miss request dropped or changed while memory was not ready");
    count_error();
  end

  assert property (@(posedge clk_i)
                   reset_d_r && !reset_i |-> ready_i && !data_v_i && !miss_v_i && !cache_req_v_i)
  else
  begin
    $display("cache outputs not idle right after reset");
    count_error();
  end

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Instruction cache testbench
//////////////////////////////////////////////////
module icache_tb;

  import icache_geom_pkg::*;
  import icache_ctrl_pkg::*;

  localparam int tests_c       = 6;
  localparam int cycle_limit_c = 200 * tests_c;

  logic      clk_i;
  logic      reset_i;
  logic      fetch_v_i;
  fetch_op_e fetch_op_i;
  addr_t     fetch_vaddr_i;
  logic      ready_o;
  tag_t      ptag_i;
  logic      ptag_v_i;
  word_t     data_o;
  logic      data_v_o;
  logic      miss_v_o;
  logic      cache_req_v_o;
  addr_t     cache_req_addr_o;
  way_t      cache_req_way_o;
  logic      cache_req_ready_i;
  logic      fill_v_i;
  block_t    fill_data_i;

  // Expected outcome of the fetch in flight
  logic      exp_hit;
  way_t      exp_way;
  int        check_errors;
  int        hold_force = -1;
  int        test_num = 0;
  int        tests_failed = 0;
  int        errors_at_start = 0;

  // Reference cache state
  logic      model_valid [sets_c][ways_c];
  tag_t      model_tag   [sets_c][ways_c];
  way_t      model_lru   [sets_c];

  icache_top #(.sets_p(sets_c)) uut (.*);

  icache_tb_checks checks
    (.clk_i(clk_i), .reset_i(reset_i)
     , .fetch_v_i(fetch_v_i), .fetch_op_i(fetch_op_i), .fetch_vaddr_i(fetch_vaddr_i)
     , .ptag_v_i(ptag_v_i), .ready_i(ready_o)
     , .data_i(data_o), .data_v_i(data_v_o), .miss_v_i(miss_v_o)
     , .cache_req_v_i(cache_req_v_o), .cache_req_addr_i(cache_req_addr_o)
     , .cache_req_way_i(cache_req_way_o), .cache_req_ready_i(cache_req_ready_i)
     , .fill_v_i(fill_v_i), .exp_hit_i(exp_hit), .exp_way_i(exp_way)
     , .errors_o(check_errors)
     );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic word_t mem_word(input addr_t a);
    return {16'h0000, {2'b00, a[15:2]} ^ 16'hA5C3};
  endfunction

  // Word 0 sits in the low half of the block
  function automatic block_t block_at(input addr_t blk);
    return {mem_word(blk + 16'd4), mem_word(blk)};
  endfunction

  task automatic wait_ready();
    while (!ready_o)
    begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // Hit or miss and victim way, from the cache rules
  task automatic predict(input addr_t addr);
    index_t idx;
    tag_t   tag;
    logic   hit;
    way_t   way;
    idx = addr[index_lsb_c +: index_width_c];
    tag = addr[tag_lsb_c +: tag_width_c];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < ways_c; w++)
    begin
      if (model_valid[idx][w] && model_tag[idx][w] == tag)
      begin
        hit = 1'b1;
        way = (w == 1);
      end
    end
    if (hit)
    begin
      model_lru[idx] = ~way;
    end
    else
    begin
      way = !model_valid[idx][0] ? 1'b0 : !model_valid[idx][1] ? 1'b1 : model_lru[idx];
      model_valid[idx][way] = 1'b1;
      model_tag[idx][way]   = tag;
    end
    exp_hit = hit;
    exp_way = way;
  endtask

  task automatic fetch_word(input addr_t addr, input logic tag_ok);
    wait_ready();
    if (tag_ok)
    begin
      predict(addr);
    end
    fetch_v_i     = 1'b1;
    fetch_op_i    = e_op_fetch;
    fetch_vaddr_i = addr;
    @(posedge clk_i);
    #2;
    fetch_v_i = 1'b0;
    ptag_i    = addr[tag_lsb_c +: tag_width_c];
    ptag_v_i  = tag_ok;
    @(posedge clk_i);
    #2;
    ptag_v_i = 1'b0;
    @(posedge clk_i);
    #2;
    // A miss keeps ready low until its fill lands
    wait_ready();
  endtask

  task automatic flush_cache();
    wait_ready();
    fetch_v_i  = 1'b1;
    fetch_op_i = e_op_flush;
    @(posedge clk_i);
    #2;
    fetch_v_i  = 1'b0;
    fetch_op_i = e_op_fetch;
    for (int s = 0; s < sets_c; s++)
    begin
      model_valid[s][0] = 1'b0;
      model_valid[s][1] = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    int failed;
    failed = check_errors - errors_at_start;
    test_num++;
    if (failed == 0)
    begin
      $display("test %0d %s: ok", test_num, name);
    end
    else
    begin
      $display("test %0d %s: %0d check failures", test_num, name, failed);
      tests_failed++;
    end
    errors_at_start = check_errors;
  endtask

  //////////////////////////////////////////////////
  // Memory model

  initial
  begin
    addr_t blk;
    int    hold;
    int    delay;
    forever
    begin
      @(posedge clk_i);
      #2;
      if (!reset_i && cache_req_v_o)
      begin
        blk  = cache_req_addr_o;
        hold = (hold_force >= 0) ? hold_force : $urandom_range(0, 3);
        repeat (hold)
        begin
          @(posedge clk_i);
          #2;
        end
        cache_req_ready_i = 1'b1;
        @(posedge clk_i);
        #2;
        cache_req_ready_i = 1'b0;
        delay = $urandom_range(1, 6);
        repeat (delay - 1)
        begin
          @(posedge clk_i);
          #2;
        end
        fill_v_i    = 1'b1;
        fill_data_i = block_at(blk);
        @(posedge clk_i);
        #2;
        fill_v_i = 1'b0;
      end
    end
  end

  // Watchdog
  initial
  begin
    repeat (cycle_limit_c) @(posedge clk_i);
    $display("watchdog expired after %0d cycles", cycle_limit_c);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    void'($urandom(17));
    reset_i           = 1'b1;
    fetch_v_i         = 1'b0;
    fetch_op_i        = e_op_fetch;
    fetch_vaddr_i     = '0;
    ptag_i            = '0;
    ptag_v_i          = 1'b0;
    cache_req_ready_i = 1'b0;
    fill_v_i          = 1'b0;
    fill_data_i       = '0;
    exp_hit           = 1'b0;
    exp_way           = 1'b0;
    for (int s = 0; s < sets_c; s++)
    begin
      model_valid[s][0] = 1'b0;
      model_valid[s][1] = 1'b0;
      model_tag[s][0]   = '0;
      model_tag[s][1]   = '0;
      model_lru[s]      = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    fetch_word(16'h1230, 1'b1);
    finish_test("miss after reset");

    fetch_word(16'h1230, 1'b1);
    fetch_word(16'h1234, 1'b1);
    finish_test("hit after fill");

    // Three tags sharing set 9
    fetch_word(16'h2a48, 1'b1);
    fetch_word(16'h2ac8, 1'b1);
    fetch_word(16'h2a4c, 1'b1);
    fetch_word(16'h2ac8, 1'b1);
    fetch_word(16'h2b48, 1'b1);
    finish_test("lru replacement");

    flush_cache();
    fetch_word(16'h1230, 1'b1);
    finish_test("miss after flush");

    fetch_word(16'h2b4c, 1'b0);
    fetch_word(16'h1234, 1'b1);
    finish_test("no physical tag");

    hold_force = 3;
    fetch_word(16'h7f18, 1'b1);
    hold_force = -1;
    fetch_word(16'h7f1c, 1'b1);
    finish_test("request back-pressure");

    $display("tests run %0d, tests failed %0d, check failures %0d",
             test_num, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/icache_geom_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_fetch_stage.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_hit_select.sv
design/icache_miss_ctrl.sv
design/icache_top.sv
bench/icache_tb_checks.sv
bench/icache_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module icache_tb -Mdir obj_dir

run: compile
	./obj_dir/Vicache_tb | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
